// ==== common/eth_tx_defines.svh ====
`ifndef ETH_TX_DEFINES_SVH
`define ETH_TX_DEFINES_SVH

// Memory word address, 512 words
`define ETH_ADDR_W 9

// Frame length in octets, 1 to 2047
`define ETH_LEN_W 11

`define ETH_PREAMBLE_OCTETS 7     // 0x55 octets ahead of the SFD

// Start-of-idle high after the last FCS bit, in CLK cycles
`define ETH_TAIL_CYCLES 6

`define ETH_LINK_PULSE_CYCLES 2   // Normal link pulse width in CLK cycles

`endif

// ==== common/eth_frame_pkg.sv ====
`default_nettype none

package eth_frame_pkg;

  typedef logic [7:0] octet_t;

  // Memory word, element 3 (bits 31:24) is the first byte on the wire
  typedef octet_t [3:0] data_word_t;

  typedef logic [31:0] crc_t;

  localparam octet_t ETH_PREAMBLE_OCTET = 8'h55;
  localparam octet_t ETH_SFD            = 8'hD5;

  // Reflected form of 0x04C11DB7
  localparam crc_t ETH_CRC_POLY = 32'hEDB8_8320;
  localparam crc_t ETH_CRC_INIT = 32'hFFFF_FFFF;

  localparam int ETH_FCS_OCTETS = 4;   // FCS length in octets

endpackage

`default_nettype wire

// ==== common/eth_tx_ctrl_pkg.sv ====
`default_nettype none

package eth_tx_ctrl_pkg;

  // Transmit sequence, one value per part of the frame
  typedef enum logic [2:0] {
    IDLE, PREAMBLE, SFD, DATA, FCS, TAIL, LINK
  } tx_phase_e;

  // What the Manchester encoder puts on the line
  typedef enum logic [1:0] {
    SILENT, ENCODE, HIGH
  } line_mode_e;

endpackage

`default_nettype wire

// ==== common/octet_if.sv ====
`default_nettype none
`timescale 1ns/10ps

// Payload octet stream from the word reader to the shifter
interface octet_if;
  logic                  take;   // Sink loads a payload octet
  eth_frame_pkg::octet_t octet;  // Valid while avail is high
  logic                  avail;  // Current word still holds unsent octets
  logic                  last;   // Presented octet ends the payload

  modport src
  (
    input  take,
    output octet,
    output avail,
    output last
  );

  modport sink
  (
    output take,
    input  octet,
    input  avail,
    input  last
  );

  modport mon
  (
    input take,
    input octet
  );
endinterface

`default_nettype wire

// ==== logic/tx_ctrl.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "eth_tx_defines.svh"

module tx_ctrl
(
  input  wire logic                       CLK,
  input  wire logic                       RST,
  input  wire logic                       start,
  input  wire logic [`ETH_LEN_W-1:0]      send_len,
  input  wire logic                       link_pulse,
  input  wire logic                       abort,
  input  wire logic                       last,
  input  wire logic                       octet_done,
  output logic                            begin_frame,
  output logic                            crc_clear,
  output eth_tx_ctrl_pkg::tx_phase_e      phase,
  output logic [1:0]                      fcs_index,
  output eth_tx_ctrl_pkg::line_mode_e     line_mode,
  output logic                            done
);
  import eth_tx_ctrl_pkg::*;
  import eth_frame_pkg::*;

  logic [3:0]            cnt;          // Preamble octets, tail or link cycles
  logic [`ETH_LEN_W-1:0] len_q;        // Data octets still to send
  logic                  last_taken;   // Octet now on the wire is the final one
  logic                  od_q;         // First cycle of a new octet
  logic                  done_pre;
  logic                  abort_hit;
  logic                  end_data;

  assign begin_frame = start & (phase == IDLE);
  assign abort_hit   = abort & (phase != IDLE);
  assign end_data    = last_taken | (len_q == `ETH_LEN_W'(1));

  always_comb
  begin
    case (phase)
      PREAMBLE, SFD, DATA, FCS: line_mode = ENCODE;
      TAIL, LINK:               line_mode = HIGH;
      default:                  line_mode = SILENT;
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      phase      <= IDLE;
      cnt        <= 4'd0;
      fcs_index  <= 2'd0;
      len_q      <= '0;
      last_taken <= 1'b0;
      od_q       <= 1'b0;
      crc_clear  <= 1'b0;
      done_pre   <= 1'b0;
      done       <= 1'b0;
    end
    else
    begin
      od_q      <= octet_done;
      crc_clear <= begin_frame;
      done_pre  <= 1'b0;
      done      <= done_pre | abort_hit;
      if (abort_hit)
        phase <= IDLE;   // Line is forced low by the encoder
      else
      begin
        case (phase)
          IDLE:
          begin
            cnt        <= 4'd0;
            fcs_index  <= 2'd0;
            last_taken <= 1'b0;
            if (start)
            begin
              phase <= PREAMBLE;
              len_q <= send_len;
            end
            else if (link_pulse)
              phase <= LINK;
          end
          PREAMBLE:
          begin
            if (octet_done)
            begin
              cnt <= cnt + 4'd1;
              if (cnt == 4'(`ETH_PREAMBLE_OCTETS - 1))
                phase <= SFD;
            end
          end
          SFD:
          begin
            if (octet_done)
              phase <= DATA;
          end
          DATA:
          begin
            if (od_q)
              last_taken <= last;   // Load cycle of a payload octet
            if (octet_done)
            begin
              len_q <= len_q - 1'b1;
              if (end_data)
                phase <= FCS;
            end
          end
          FCS:
          begin
            if (octet_done)
            begin
              fcs_index <= fcs_index + 2'd1;
              if (fcs_index == 2'(ETH_FCS_OCTETS - 1))
              begin
                phase <= TAIL;
                cnt   <= 4'd0;
              end
            end
          end
          TAIL:
          begin
            cnt <= cnt + 4'd1;
            if (cnt == 4'(`ETH_TAIL_CYCLES - 1))
            begin
              phase    <= IDLE;
              done_pre <= 1'b1;
            end
          end
          LINK:
          begin
            cnt <= cnt + 4'd1;
            if (cnt == 4'(`ETH_LINK_PULSE_CYCLES - 1))
            begin
              phase    <= IDLE;
              done_pre <= 1'b1;
            end
          end
          default: phase <= IDLE;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/word_fetch.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "eth_tx_defines.svh"

module word_fetch
(
  input  wire logic                      CLK,
  input  wire logic                      RST,
  input  wire logic                      begin_frame,
  input  wire logic [`ETH_LEN_W-1:0]     send_len,
  input  wire eth_frame_pkg::data_word_t rd_data,
  output logic [`ETH_ADDR_W-1:0]         rd_addr,
  output logic                           rd_en,
  octet_if.src                           oct
);
  import eth_frame_pkg::*;

  data_word_t            cur_word;
  data_word_t            nxt_word;    // Prefetched while cur_word drains
  logic                  cur_valid;
  logic                  nxt_valid;
  logic                  rd_pend;     // Memory answers this cycle
  logic [1:0]            byte_idx;    // Position in send order
  logic [`ETH_LEN_W-1:0] remaining;   // Octets not yet taken
  logic [`ETH_ADDR_W-1:0] addr;
  logic                  fetch_next;
  logic                  word_end;

  assign oct.octet  = cur_word[~byte_idx];   // Top byte first
  assign oct.avail  = cur_valid;
  assign oct.last   = cur_valid & (remaining == `ETH_LEN_W'(1));
  assign fetch_next = oct.take & (byte_idx == 2'd0) & (remaining > `ETH_LEN_W'(4));
  assign word_end   = (byte_idx == 2'd3) | oct.last;
  assign rd_addr    = addr;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      rd_en     <= 1'b0;
      rd_pend   <= 1'b0;
      cur_valid <= 1'b0;
      nxt_valid <= 1'b0;
      byte_idx  <= 2'd0;
      remaining <= '0;
      addr      <= '0;
    end
    else
    begin
      rd_en   <= begin_frame | fetch_next;
      rd_pend <= rd_en;
      if (rd_en)
        addr <= addr + 1'b1;
      if (begin_frame)
      begin
        cur_valid <= 1'b0;
        nxt_valid <= 1'b0;
        byte_idx  <= 2'd0;
        remaining <= send_len;
        addr      <= '0;
      end
      else if (oct.take)
      begin
        remaining <= remaining - 1'b1;
        byte_idx  <= word_end ? 2'd0 : byte_idx + 2'd1;
        if (word_end)
        begin
          cur_valid <= nxt_valid & ~oct.last;
          nxt_valid <= 1'b0;
        end
      end
      else if (rd_pend)
      begin
        if (cur_valid)
          nxt_valid <= 1'b1;
        else
          cur_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (oct.take & word_end)
      cur_word <= nxt_word;
    else if (rd_pend)
    begin
      if (cur_valid)
        nxt_word <= rd_data;
      else
        cur_word <= rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== logic/crc32_gen.sv ====
`default_nettype none
`timescale 1ns/10ps

module crc32_gen
(
  input  wire logic       CLK,
  input  wire logic       RST,
  input  wire logic       crc_clear,
  input  wire logic [1:0] fcs_index,
  octet_if.mon            oct,
  output eth_frame_pkg::octet_t fcs_octet
);
  import eth_frame_pkg::*;

  crc_t crc_q;

  // One octet through the reflected CRC-32, low bit first
  function automatic crc_t crc_step(input crc_t crc, input octet_t data);
    crc_t c;
    c = crc ^ {24'h0, data};
    for (int i = 0; i < 8; i++)
      c = c[0] ? ((c >> 1) ^ ETH_CRC_POLY) : (c >> 1);
    return c;
  endfunction

  // FCS goes out complemented, low byte first
  assign fcs_octet = ~crc_q[{fcs_index, 3'b000} +: 8];

  always_ff @(posedge CLK)
  begin
    if (!RST)
      crc_q <= ETH_CRC_INIT;
    else if (crc_clear)
      crc_q <= ETH_CRC_INIT;
    else if (oct.take)
      crc_q <= crc_step(crc_q, oct.octet);
  end

endmodule

`default_nettype wire

// ==== logic/octet_shifter.sv ====
`default_nettype none
`timescale 1ns/10ps

module octet_shifter
(
  input  wire logic                       CLK,
  input  wire logic                       RST,
  input  wire eth_tx_ctrl_pkg::tx_phase_e phase,
  input  wire eth_frame_pkg::octet_t      fcs_octet,
  octet_if.sink                           oct,
  output logic                            tx_bit,
  output logic                            octet_done
);
  import eth_tx_ctrl_pkg::*;
  import eth_frame_pkg::*;

  octet_t     sr;          // Bits still to go, LSB on the line
  octet_t     next_octet;
  logic [2:0] bit_cnt;
  logic       half;        // Second half of the current bit
  logic       active;
  logic       load;

  assign active = (phase == PREAMBLE) | (phase == SFD) | (phase == DATA) | (phase == FCS);
  // First half of bit 0, the new octet goes straight to the line
  assign load       = active & ~half & (bit_cnt == 3'd0);
  assign oct.take   = load & (phase == DATA) & oct.avail;
  assign tx_bit     = load ? next_octet[0] : sr[0];
  assign octet_done = active & half & (bit_cnt == 3'd7);

  always_comb
  begin
    case (phase)
      PREAMBLE: next_octet = ETH_PREAMBLE_OCTET;
      SFD:      next_octet = ETH_SFD;
      DATA:     next_octet = oct.octet;
      FCS:      next_octet = fcs_octet;
      default:  next_octet = 8'h00;
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      bit_cnt <= 3'd0;
      half    <= 1'b0;
    end
    else if (!active)
    begin
      bit_cnt <= 3'd0;
      half    <= 1'b0;
    end
    else
    begin
      half <= ~half;
      if (half)
        bit_cnt <= bit_cnt + 3'd1;   // Wraps to 0 after octet_done
    end
  end

  always_ff @(posedge CLK)
  begin
    if (load)
      sr <= next_octet;
    else if (half)
      sr <= {1'b0, sr[7:1]};
  end

endmodule

`default_nettype wire

// ==== logic/manchester_enc.sv ====
`default_nettype none
`timescale 1ns/10ps

module manchester_enc
(
  input  wire logic                        CLK,
  input  wire logic                        RST,
  input  wire logic                        tx_bit,
  input  wire eth_tx_ctrl_pkg::line_mode_e line_mode,
  input  wire logic                        abort,
  output logic                             tx_wire
);
  import eth_tx_ctrl_pkg::*;

  logic       half_q;
  logic       second;   // Second half-bit of the current bit

  // Entering ENCODE always starts on a first half
  assign second = half_q;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      tx_wire <= 1'b0;
      half_q  <= 1'b0;
    end
    else
    begin
      half_q <= (line_mode == ENCODE) & ~second;
      if (abort)
        tx_wire <= 1'b0;
      else
      begin
        case (line_mode)
          ENCODE:  tx_wire <= second ? tx_bit : ~tx_bit;   // A one goes low to high
          HIGH:    tx_wire <= 1'b1;
          default: tx_wire <= 1'b0;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/eth_tx_top.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "eth_tx_defines.svh"

module eth_tx_top
(
  input  wire logic                      CLK,
  input  wire logic                      RST,
  input  wire logic                      start,
  input  wire logic [`ETH_LEN_W-1:0]     send_len,
  input  wire logic                      link_pulse,
  input  wire logic                      abort,
  input  wire eth_frame_pkg::data_word_t rd_data,
  output logic [`ETH_ADDR_W-1:0]         rd_addr,
  output logic                           rd_en,
  output logic                           tx_wire,
  output logic                           done
);
  import eth_tx_ctrl_pkg::*;
  import eth_frame_pkg::*;

  tx_phase_e  phase;
  line_mode_e line_mode;
  octet_t     fcs_octet;
  logic [1:0] fcs_index;
  logic       begin_frame;
  logic       crc_clear;
  logic       octet_done;
  logic       tx_bit;

  octet_if oct_bus ();

  tx_ctrl i_ctrl
  (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start),
    .send_len    (send_len),
    .link_pulse  (link_pulse),
    .abort       (abort),
    .last        (oct_bus.last),
    .octet_done  (octet_done),
    .begin_frame (begin_frame),
    .crc_clear   (crc_clear),
    .phase       (phase),
    .fcs_index   (fcs_index),
    .line_mode   (line_mode),
    .done        (done)
  );

  word_fetch i_fetch
  (
    .CLK         (CLK),
    .RST         (RST),
    .begin_frame (begin_frame),
    .send_len    (send_len),
    .rd_data     (rd_data),
    .rd_addr     (rd_addr),
    .rd_en       (rd_en),
    .oct         (oct_bus.src)
  );

  crc32_gen i_crc
  (
    .CLK       (CLK),
    .RST       (RST),
    .crc_clear (crc_clear),
    .fcs_index (fcs_index),
    .oct       (oct_bus.mon),
    .fcs_octet (fcs_octet)
  );

  octet_shifter i_shift
  (
    .CLK        (CLK),
    .RST        (RST),
    .phase      (phase),
    .fcs_octet  (fcs_octet),
    .oct        (oct_bus.sink),
    .tx_bit     (tx_bit),
    .octet_done (octet_done)
  );

  manchester_enc i_enc
  (
    .CLK       (CLK),
    .RST       (RST),
    .tx_bit    (tx_bit),
    .line_mode (line_mode),
    .abort     (abort),
    .tx_wire   (tx_wire)
  );

endmodule

`default_nettype wire

// ==== test/eth_tx_chk.sv ====
`default_nettype none
`timescale 1ns/10ps

module eth_tx_chk
(
  input wire logic                       CLK,
  input wire logic                       RST,
  input wire logic                       rd_en,
  input wire logic                       done,
  input wire logic                       tx_wire,
  input wire eth_tx_ctrl_pkg::tx_phase_e phase
);
  import eth_tx_ctrl_pkg::*;

  int unsigned fails = 0;   // Read by the testbench at the end of the run

  rd_en_single: assert property (@(posedge CLK) disable iff (!RST) rd_en |=> !rd_en)
    else
    begin
      fails++;
      $error("rd_en high for more than one cycle");
    end

  done_single: assert property (@(posedge CLK) disable iff (!RST) done |=> !done)
    else
    begin
      fails++;
      $error("done high for more than one cycle");
    end

  // The encoder output lags the phase by one cycle
  idle_quiet: assert property (@(posedge CLK) disable iff (!RST)
    (phase == IDLE) && ($past(phase) == IDLE) |-> !tx_wire)
    else
    begin
      fails++;
      $error("tx_wire high while idle");
    end

  read_in_frame: assert property (@(posedge CLK) disable iff (!RST) rd_en |-> phase != IDLE)
    else
    begin
      fails++;
      $error("memory read outside a frame");
    end

endmodule

bind eth_tx_top eth_tx_chk i_chk
(
  .CLK     (CLK),
  .RST     (RST),
  .rd_en   (rd_en),
  .done    (done),
  .tx_wire (tx_wire),
  .phase   (phase)
);

`default_nettype wire

// ==== test/eth_tx_tb.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "eth_tx_defines.svh"

module tb_clk_gen
(
  output logic CLK
);
  initial
  begin
    CLK = 1'b0;
    forever
      #5 CLK = ~CLK;   // 10 ns period
  end
endmodule

module eth_tx_tb;
  typedef struct {
    int len;        // Payload octets
    int abort_at;   // Payload octets on the line before abort, 0 for none
    bit link;       // Link pulse row
  } row_t;

  localparam int NROWS = 8;

  logic                   CLK;
  logic                   RST;
  logic                   start;
  logic [`ETH_LEN_W-1:0]  send_len;
  logic                   link_pulse;
  logic                   abort;
  logic [31:0]            rd_data = 32'h0;
  logic [`ETH_ADDR_W-1:0] rd_addr;
  logic                   rd_en;
  logic                   tx_wire;
  logic                   done;

  logic [31:0]            mem [0:(1 << `ETH_ADDR_W) - 1];
  logic                   mem_rd;
  logic [`ETH_ADDR_W-1:0] mem_addr;
  logic [31:0]            lfsr;
  logic [`ETH_ADDR_W-1:0] rd_log [$];   // Addresses of all reads in the current row
  int                     done_cnt = 0;
  int                     errors = 0;
  int                     timeouts = 0;
  row_t                   tbl [NROWS];

  tb_clk_gen i_clk (.CLK(CLK));

  eth_tx_top i_dut
  (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .send_len   (send_len),
    .link_pulse (link_pulse),
    .abort      (abort),
    .rd_data    (rd_data),
    .rd_addr    (rd_addr),
    .rd_en      (rd_en),
    .tx_wire    (tx_wire),
    .done       (done)
  );

  // Word memory, answers one cycle after rd_en
  always @(posedge CLK)
  begin
    mem_rd   = rd_en;
    mem_addr = rd_addr;
    #1;
    if (mem_rd)
      rd_data = mem[mem_addr];
  end

  always @(posedge CLK)
  begin
    if (RST && rd_en)
      rd_log.push_back(rd_addr);
    if (RST && done)
      done_cnt++;
  end

  function automatic logic lfsr_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b)
      lfsr = lfsr ^ 32'hD000_0001;
    return b;
  endfunction

  task automatic fill_memory();
    logic [31:0] w;
    lfsr = 32'ha3a180af;
    for (int a = 0; a < (1 << `ETH_ADDR_W); a++)
    begin
      w = 32'h0;
      for (int b = 0; b < 32; b++)
        w = {w[30:0], lfsr_bit()};
      mem[a] = w;
    end
  endtask

  // Plain MSB-first CRC-32, octet bits fed in line order
  function automatic logic [31:0] crc_ref_byte(input logic [31:0] crc, input logic [7:0] b);
    logic [31:0] c;
    logic        fb;
    c = crc;
    for (int i = 0; i < 8; i++)
    begin
      fb = c[31] ^ b[i];
      c  = {c[30:0], 1'b0};
      if (fb)
        c = c ^ 32'h04C1_1DB7;
    end
    return c;
  endfunction

  // FCS word, octet 0 in bits 7:0
  function automatic logic [31:0] fcs_word(input logic [31:0] crc);
    logic [31:0] r;
    for (int i = 0; i < 32; i++)
      r[i] = crc[31 - i];
    return ~r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // Both halves of eight bits, LSB first
  task automatic decode_octet(output logic [7:0] v);
    logic h1;
    logic h2;
    for (int i = 0; i < 8; i++)
    begin
      @(negedge CLK);
      h1 = tx_wire;
      @(negedge CLK);
      h2 = tx_wire;
      check_value("tx_wire half-bit xor", 32'(h1 ^ h2), 32'd1);
      v[i] = h2;
    end
  endtask

  task automatic wait_done(input int limit, output int n_cyc, output int n_high);
    logic seen;
    seen   = 1'b0;
    n_cyc  = 0;
    n_high = 0;
    while (!seen && n_cyc < limit)
    begin
      @(negedge CLK);
      n_cyc++;
      if (done)
        seen = 1'b1;
      else if (tx_wire)
        n_high++;
    end
    if (!seen)
    begin
      timeouts++;
      $display("Timeout: done did not pulse within %0d cycles", limit);
    end
    else
      check_value("tx_wire with done", 32'(tx_wire), 32'd0);
  endtask

  task automatic send_frame(input row_t r);
    logic [7:0]  exp_q [$];
    logic [7:0]  got;
    logic [31:0] crc;
    logic [31:0] fcs;
    int          n_oct;
    int          n_cyc;
    int          n_high;
    int          done_before;
    crc = 32'hFFFF_FFFF;
    for (int i = 0; i < `ETH_PREAMBLE_OCTETS; i++)
      exp_q.push_back(8'h55);
    exp_q.push_back(8'hD5);
    for (int k = 0; k < r.len; k++)
    begin
      exp_q.push_back(mem[k / 4][8 * (3 - k % 4) +: 8]);   // Top byte first
      crc = crc_ref_byte(crc, exp_q[exp_q.size() - 1]);
    end
    fcs = fcs_word(crc);
    for (int i = 0; i < 4; i++)
      exp_q.push_back(fcs[8 * i +: 8]);
    n_oct = (r.abort_at > 0) ? 8 + r.abort_at : exp_q.size();
    rd_log.delete();
    done_before = done_cnt;
    @(posedge CLK);
    #1;
    send_len = `ETH_LEN_W'(r.len);
    start    = 1'b1;
    @(posedge CLK);
    #1;
    start = 1'b0;
    @(posedge CLK);   // First half-bit follows this edge
    for (int i = 0; i < n_oct; i++)
    begin
      decode_octet(got);
      check_value($sformatf("line octet %0d", i), 32'(got), 32'(exp_q[i]));
    end
    if (r.abort_at > 0)
    begin
      @(posedge CLK);
      #1;
      abort = 1'b1;
      @(posedge CLK);
      #1;
      abort = 1'b0;
      wait_done(4, n_cyc, n_high);
      check_value("abort to done cycles", n_cyc, 1);
      repeat (4)
      begin
        @(negedge CLK);
        check_value("tx_wire after abort", 32'(tx_wire), 32'd0);
      end
    end
    else
    begin
      wait_done(`ETH_TAIL_CYCLES + 8, n_cyc, n_high);
      check_value("tail to done cycles", n_cyc, `ETH_TAIL_CYCLES + 1);
      check_value("tail high cycles", n_high, `ETH_TAIL_CYCLES);
    end
    repeat (4) @(posedge CLK);
    check_value("done pulses", done_cnt - done_before, 1);
    if (r.abort_at == 0)
    begin
      check_value("read count", rd_log.size(), (r.len + 3) / 4);
      for (int i = 0; i < rd_log.size(); i++)
        check_value("rd_addr", 32'(rd_log[i]), i);
    end
  endtask

  task automatic send_link_pulse();
    int n_cyc;
    int n_high;
    int done_before;
    done_before = done_cnt;
    @(posedge CLK);
    #1;
    link_pulse = 1'b1;
    @(posedge CLK);
    #1;
    link_pulse = 1'b0;
    wait_done(`ETH_LINK_PULSE_CYCLES + 8, n_cyc, n_high);
    check_value("link pulse to done cycles", n_cyc, `ETH_LINK_PULSE_CYCLES + 2);
    check_value("link pulse high cycles", n_high, `ETH_LINK_PULSE_CYCLES);
    repeat (4) @(posedge CLK);
    check_value("done pulses", done_cnt - done_before, 1);
  endtask

  initial
  begin
    logic [31:0] crc;
    RST        = 1'b0;
    start      = 1'b0;
    send_len   = '0;
    link_pulse = 1'b0;
    abort      = 1'b0;
    tbl[0] = '{len: 1, abort_at: 0, link: 1'b0};
    tbl[1] = '{len: 4, abort_at: 0, link: 1'b0};
    tbl[2] = '{len: 0, abort_at: 0, link: 1'b1};
    tbl[3] = '{len: 5, abort_at: 0, link: 1'b0};
    tbl[4] = '{len: 64, abort_at: 12, link: 1'b0};   // Aborted mid payload
    tbl[5] = '{len: 64, abort_at: 0, link: 1'b0};
    tbl[6] = '{len: 2047, abort_at: 0, link: 1'b0};
    tbl[7] = '{len: 0, abort_at: 0, link: 1'b1};
    fill_memory();
    crc = 32'hFFFF_FFFF;
    for (int i = 0; i < 9; i++)
      crc = crc_ref_byte(crc, 8'(8'h31 + i));   // ASCII 123456789
    check_value("crc reference", fcs_word(crc), 32'hCBF4_3926);
    repeat (10) @(posedge CLK);
    #1;
    RST = 1'b1;
    @(negedge CLK);
    check_value("rd_en after reset", 32'(rd_en), 32'd0);
    check_value("done after reset", 32'(done), 32'd0);
    check_value("tx_wire after reset", 32'(tx_wire), 32'd0);
    for (int i = 0; i < NROWS && timeouts == 0; i++)
    begin
      if (tbl[i].link)
        send_link_pulse();
      else
        send_frame(tbl[i]);
    end
    $display("Summary: %0d mismatches, %0d timeouts, %0d assertion failures",
             errors, timeouts, i_dut.i_chk.fails);
    if (errors == 0 && timeouts == 0 && i_dut.i_chk.fails == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== eth_tx.f ====
+incdir+common
common/eth_frame_pkg.sv
common/eth_tx_ctrl_pkg.sv
common/octet_if.sv
logic/tx_ctrl.sv
logic/word_fetch.sv
logic/crc32_gen.sv
logic/octet_shifter.sv
logic/manchester_enc.sv
logic/eth_tx_top.sv
test/eth_tx_chk.sv
test/eth_tx_tb.sv

// ==== Makefile ====
TOP = eth_tx_tb

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f eth_tx.f -o $(TOP)

run: build
	@out=$$(./obj_dir/$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f eth_tx.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
